//--- verilog.f
logic/fft_sample_pkg.sv
logic/reorder_pkg.sv
logic/frame_collector.sv
logic/sample_select.sv
logic/frame_reader.sv
logic/fft_reorder_top.sv
tb/tb_fft_reorder.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the FFT reorder testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
    --timescale 1ns/1ns \
    -f verilog.f \
    --top-module tb_fft_reorder \
    -o sim_fft_reorder

# a failing check ends the simulator with a non-zero status
sim_out=$(./obj_dir/sim_fft_reorder 2>&1 || true)
echo "$sim_out"

if grep -q 'All tests passed!' <<< "$sim_out"; then
    echo "simulation PASSED"
    exit 0
else
    echo "simulation FAILED"
    exit 1
fi

//--- tb/tb_fft_reorder.sv
`timescale 1ns/1ns

module tb_fft_reorder;

    localparam int FRAME_LEN     = reorder_pkg::FRAME_LEN;
    localparam int ADDR_W        = reorder_pkg::ADDR_W;
    localparam int DATA_WIDTH    = fft_sample_pkg::SAMPLE_W;
    localparam int DRIVE_DLY     = 2;    // ns after the rising edge
    localparam int VALID_TIMEOUT = 2000; // cycles to wait for an output burst
    localparam int SEND_TIMEOUT  = 2000; // cycles allowed to push one input frame

    localparam logic [31:0] LFSR_SEED = 32'hf9529247;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic                         i_clk;
    logic                         i_reset;
    logic                         i_valid;
    fft_sample_pkg::cplx_sample_t i_sample;
    reorder_pkg::read_order_e     i_order;
    logic                         o_valid;
    fft_sample_pkg::cplx_sample_t o_sample;

    logic [31:0] lfsr_state = LFSR_SEED;
    int          cycle_cnt  = 0;
    string       test_name  = "";

    // expected output stream, and the cycle in which each burst has to start
    fft_sample_pkg::cplx_sample_t exp_q[$];
    int                           start_q[$];

    fft_reorder_top #(
        .DATA_WIDTH (DATA_WIDTH),
        .FRAME_LEN  (FRAME_LEN),
        .ADDR_W     (ADDR_W)
    ) dut_i (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_valid  (i_valid),
        .i_sample (i_sample),
        .i_order  (i_order),
        .o_valid  (o_valid),
        .o_sample (o_sample)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    // index of the most recent rising edge
    always @(posedge i_clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // one LFSR step per bit handed out
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // output slot j of a bit-reversed frame holds input index reverse_index(j)
    function automatic int reverse_index(input int j);
        int r;
        r = 0;
        for (int b = 0; b < ADDR_W; b++) begin
            if (((j >> b) & 1) != 0) begin
                r = r | (1 << (ADDR_W - 1 - b));
            end
        end
        return r;
    endfunction

    // mode 0 natural, 1 bit-reversed, 2 random per frame
    function automatic reorder_pkg::read_order_e pick_order(input int mode);
        logic [31:0] r;
        if (mode == 2) begin
            r = rand_bits(1);
            return reorder_pkg::read_order_e'(r[0]);
        end
        return reorder_pkg::read_order_e'(mode[0]);
    endfunction

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic report_problem(input string what);
        $display("%s: %s", test_name, what);
        stop_on_failure();
    endtask

    task automatic compare_sample(input string name, input int idx,
                                  input fft_sample_pkg::cplx_sample_t exp,
                                  input fft_sample_pkg::cplx_sample_t act);
        if (act !== exp) begin
            $display("[ERROR] %s: sample %0d expected re=%0d im=%0d, actual re=%0d im=%0d",
                     name, idx, exp.re, exp.im, act.re, act.im);
            stop_on_failure();
        end
    endtask

    task automatic compare_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s: burst length expected %0d, actual %0d", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic compare_cycle(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("[ERROR] %s: first o_valid expected in cycle %0d, actual %0d",
                     name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic compare_valid(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[ERROR] %s: o_valid expected %b, actual %b", name, exp, act);
            stop_on_failure();
        end
    endtask

    task automatic apply_reset(input int cycles);
        i_reset = 1'b1;
        i_valid = 1'b0; // a sample driven in this cycle is dropped with the partial frame
        repeat (cycles) @(posedge i_clk);
        #DRIVE_DLY;
        i_reset = 1'b0;
    endtask

    task automatic drive_idle();
        @(posedge i_clk);
        #DRIVE_DLY;
        i_valid = 1'b0;
    endtask

    // pushes n_samples into the DUT, a gap in a cycle with probability gap_num/8;
    // only a complete frame goes into the model
    task automatic send_frame(input reorder_pkg::read_order_e order, input int gap_num,
                              input bit extremes, input int n_samples);
        fft_sample_pkg::cplx_sample_t frame [FRAME_LEN];
        fft_sample_pkg::cplx_sample_t smp;
        logic [31:0]                  bits;
        int                           cnt;
        int                           cycles;
        int                           capture;
        int                           src;
        cnt    = 0;
        cycles = 0;
        while (cnt < n_samples) begin
            @(posedge i_clk);
            #DRIVE_DLY;
            cycles++;
            if (cycles > SEND_TIMEOUT) begin
                report_problem("input frame was not complete within the cycle limit");
            end
            bits   = rand_bits(32);
            smp.re = bits[31:16];
            smp.im = bits[15:0];
            if (extremes && (cnt % 4 == 0)) begin
                smp.re = 16'h8000;
                smp.im = 16'h7fff;
            end else if (extremes && (cnt % 4 == 1)) begin
                smp.re = 16'h7fff;
                smp.im = 16'h8000;
            end
            i_sample = smp; // gap cycles carry junk that must not be stored
            i_order  = order;
            bits     = rand_bits(3);
            if (bits < gap_num) begin
                i_valid = 1'b0;
            end else begin
                i_valid    = 1'b1;
                frame[cnt] = smp;
                cnt++;
            end
        end
        if (n_samples == FRAME_LEN) begin
            capture = cycle_cnt + 1; // the next rising edge takes the last sample
            for (int j = 0; j < FRAME_LEN; j++) begin
                src = (order == reorder_pkg::ORDER_BITREV) ? reverse_index(j) : j;
                exp_q.push_back(frame[src]);
            end
            start_q.push_back(capture + 2);
        end
    endtask

    // outputs are sampled at the falling edge, away from the driving edge
    task automatic check_frames(input int n);
        int waited;
        int burst;
        int start;
        for (int f = 0; f < n; f++) begin
            waited = 0;
            @(negedge i_clk);
            while (o_valid !== 1'b1) begin
                waited++;
                if (waited > VALID_TIMEOUT) begin
                    report_problem("timed out waiting for o_valid");
                end
                @(negedge i_clk);
            end
            if (start_q.size() == 0) begin
                report_problem("o_valid went high with no complete input frame");
            end
            start = start_q.pop_front();
            compare_cycle(test_name, start, cycle_cnt);
            burst = 0;
            while (o_valid === 1'b1 && burst < FRAME_LEN) begin
                compare_sample(test_name, burst, exp_q.pop_front(), o_sample);
                burst++;
                if (burst < FRAME_LEN) begin
                    @(negedge i_clk);
                end
            end
            compare_count(test_name, FRAME_LEN, burst);
        end
    endtask

    task automatic expect_idle(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            compare_valid(test_name, 1'b0, o_valid);
        end
    endtask

    // the driver and the checker run side by side, so frames overlap readout
    task automatic run_frames(input int n, input int gap_num, input int order_mode,
                              input bit extremes);
        fork
            begin
                for (int f = 0; f < n; f++) begin
                    send_frame(pick_order(order_mode), gap_num, extremes, FRAME_LEN);
                end
                drive_idle();
            end
            check_frames(n);
        join
        expect_idle(40); // nothing repeated after the last burst
    endtask

    initial begin
        i_reset  = 1'b1;
        i_valid  = 1'b0;
        i_sample = '0;
        i_order  = reorder_pkg::ORDER_NATURAL;
        apply_reset(5);

        test_name = "idle after reset";
        expect_idle(100);

        test_name = "natural frame";
        run_frames(1, 0, 0, 1'b0);

        test_name = "bit-reversed frame with extremes";
        run_frames(1, 0, 1, 1'b1);

        test_name = "bit-reversed frame";
        run_frames(2, 0, 1, 1'b0);

        test_name = "natural frames with gaps";
        run_frames(3, 2, 0, 1'b0);

        test_name = "bit-reversed frames with gaps";
        run_frames(3, 4, 1, 1'b1);

        test_name = "mixed orders with gaps";
        run_frames(4, 3, 2, 1'b0);

        test_name = "back-to-back frames";
        run_frames(5, 0, 2, 1'b0);

        test_name = "back-to-back frames with short gaps";
        run_frames(4, 1, 2, 1'b1);

        // a partial frame is cut off by reset and never comes out
        test_name = "reset in mid-frame";
        send_frame(reorder_pkg::ORDER_BITREV, 0, 1'b0, 17);
        apply_reset(5);
        expect_idle(50);
        run_frames(1, 1, 1, 1'b0);
        run_frames(2, 0, 2, 1'b0);

        $display("All tests passed!");
        $finish;
    end

endmodule

//--- logic/fft_reorder_top.sv
`timescale 1ns/1ns

module fft_reorder_top #(
    parameter int DATA_WIDTH = fft_sample_pkg::SAMPLE_W,
    parameter int FRAME_LEN  = reorder_pkg::FRAME_LEN,
    parameter int ADDR_W     = reorder_pkg::ADDR_W
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_valid,
    input  fft_sample_pkg::cplx_sample_t i_sample,
    input  reorder_pkg::read_order_e     i_order,
    output logic                         o_valid,
    output fft_sample_pkg::cplx_sample_t o_sample
);

    fft_sample_pkg::cplx_sample_t bank_rd [0:FRAME_LEN-1];
    fft_sample_pkg::cplx_sample_t sel_sample;
    logic                         frame_done;
    reorder_pkg::read_order_e     frame_order;
    logic [ADDR_W-1:0]            rd_addr;

    frame_collector #(
        .DATA_WIDTH (DATA_WIDTH),
        .FRAME_LEN  (FRAME_LEN),
        .ADDR_W     (ADDR_W)
    ) collector_i (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_valid       (i_valid),
        .i_sample      (i_sample),
        .i_order       (i_order),
        .o_frame_done  (frame_done),
        .o_frame_order (frame_order),
        .o_bank        (bank_rd)
    );

    sample_select #(
        .DATA_WIDTH (DATA_WIDTH),
        .FRAME_LEN  (FRAME_LEN),
        .ADDR_W     (ADDR_W)
    ) select_i (
        .i_addr   (rd_addr),
        .i_bank   (bank_rd),
        .o_sample (sel_sample)
    );

    frame_reader #(
        .FRAME_LEN (FRAME_LEN),
        .ADDR_W    (ADDR_W)
    ) reader_i (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_frame_done (frame_done),
        .i_order      (frame_order),
        .i_sel_sample (sel_sample),
        .o_rd_addr    (rd_addr),
        .o_valid      (o_valid),
        .o_sample     (o_sample)
    );

endmodule

//--- logic/frame_reader.sv
`timescale 1ns/1ns

module frame_reader #(
    parameter int FRAME_LEN = 32,
    parameter int ADDR_W    = 5
) (
    input  logic                         i_clk,
    input  logic                         i_reset,
    input  logic                         i_frame_done,
    input  reorder_pkg::read_order_e     i_order,
    input  fft_sample_pkg::cplx_sample_t i_sel_sample,
    output logic [ADDR_W-1:0]            o_rd_addr,
    output logic                         o_valid,
    output fft_sample_pkg::cplx_sample_t o_sample
);

    logic                     busy;
    logic [ADDR_W-1:0]        rd_cnt;
    logic [ADDR_W-1:0]        rd_cnt_rev;
    reorder_pkg::read_order_e order_q;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            busy    <= 1'b0;
            rd_cnt  <= '0;
            order_q <= reorder_pkg::ORDER_NATURAL;
        end else if (i_frame_done) begin
            busy    <= 1'b1; // a new frame always restarts the sequence
            rd_cnt  <= '0;
            order_q <= i_order;
        end else if (busy) begin
            if (rd_cnt == ADDR_W'(FRAME_LEN - 1)) begin
                busy   <= 1'b0;
                rd_cnt <= '0;
            end else begin
                rd_cnt <= rd_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        for (int b = 0; b < ADDR_W; b++) begin
            rd_cnt_rev[b] = rd_cnt[ADDR_W-1-b];
        end
    end

    assign o_rd_addr = (order_q == reorder_pkg::ORDER_BITREV) ? rd_cnt_rev : rd_cnt;

    // valid is busy delayed by the one edge the sample register adds
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= busy;
        end
    end

    always_ff @(posedge i_clk) begin
        if (busy) begin
            o_sample <= i_sel_sample;
        end
    end

endmodule

//--- logic/sample_select.sv
`timescale 1ns/1ns

module sample_select #(
    parameter int DATA_WIDTH = 16,
    parameter int FRAME_LEN  = 32,
    parameter int ADDR_W     = 5
) (
    input  logic [ADDR_W-1:0]            i_addr,
    input  fft_sample_pkg::cplx_sample_t i_bank [0:FRAME_LEN-1],
    output fft_sample_pkg::cplx_sample_t o_sample
);

    logic signed [DATA_WIDTH-1:0] sel_re;
    logic signed [DATA_WIDTH-1:0] sel_im;

    // FRAME_LEN-to-1 selector, both signed components steered by one address
    always_comb begin
        sel_re = '0; // addresses past the frame read as zero
        sel_im = '0;
        for (int k = 0; k < FRAME_LEN; k++) begin
            if (i_addr == ADDR_W'(k)) begin
                sel_re = i_bank[k].re;
                sel_im = i_bank[k].im;
            end
        end
    end

    assign o_sample.re = sel_re;
    assign o_sample.im = sel_im;

endmodule

//--- logic/frame_collector.sv
`timescale 1ns/1ns

module frame_collector #(
    parameter int DATA_WIDTH = 16,
    parameter int FRAME_LEN  = 32,
    parameter int ADDR_W     = 5
) (
    input  logic                        i_clk,
    input  logic                        i_reset,
    input  logic                        i_valid,
    input  fft_sample_pkg::cplx_sample_t i_sample,
    input  reorder_pkg::read_order_e    i_order,
    output logic                        o_frame_done,
    output reorder_pkg::read_order_e    o_frame_order,
    output fft_sample_pkg::cplx_sample_t o_bank [0:FRAME_LEN-1]
);

    // two banks per component, indexed by bank then sample
    logic signed [DATA_WIDTH-1:0] mem_re [0:1][0:FRAME_LEN-1];
    logic signed [DATA_WIDTH-1:0] mem_im [0:1][0:FRAME_LEN-1];

    logic [ADDR_W-1:0] wr_cnt;
    logic              bank_sel; // back bank, the one being written
    logic              rd_sel;   // front bank seen by the selector
    logic              last_sample;

    assign last_sample = i_valid && (wr_cnt == ADDR_W'(FRAME_LEN - 1));

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            wr_cnt        <= '0;
            bank_sel      <= 1'b0;
            o_frame_done  <= 1'b0;
            o_frame_order <= reorder_pkg::ORDER_NATURAL;
        end else begin
            o_frame_done <= 1'b0;
            if (last_sample) begin
                wr_cnt        <= '0;
                bank_sel      <= ~bank_sel;
                o_frame_done  <= 1'b1;
                o_frame_order <= i_order; // order travels with the frame it was sent with
            end else if (i_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
        end
    end

    // the read side follows the swap one edge later, so the reader's last
    // address of a frame still sees that frame when the next one ends gapless
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            rd_sel <= 1'b1;
        end else if (o_frame_done) begin
            rd_sel <= ~bank_sel;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            mem_re[bank_sel][wr_cnt] <= i_sample.re;
            mem_im[bank_sel][wr_cnt] <= i_sample.im;
        end
    end

    always_comb begin
        for (int k = 0; k < FRAME_LEN; k++) begin
            o_bank[k].re = mem_re[rd_sel][k];
            o_bank[k].im = mem_im[rd_sel][k];
        end
    end

endmodule

//--- logic/reorder_pkg.sv
package reorder_pkg;

    parameter int FRAME_LEN = 32;               // samples per frame
    parameter int ADDR_W    = $clog2(FRAME_LEN); // index width into one frame

    // order in which a completed frame is streamed out
    typedef enum logic {
        ORDER_NATURAL = 1'b0,
        ORDER_BITREV  = 1'b1
    } read_order_e;

endpackage

//--- logic/fft_sample_pkg.sv
package fft_sample_pkg;

    // width of one real or imaginary component
    parameter int SAMPLE_W = 16;

    // one complex frequency sample as delivered by the butterfly datapath
    typedef struct packed {
        logic signed [SAMPLE_W-1:0] re;
        logic signed [SAMPLE_W-1:0] im;
    } cplx_sample_t;

endpackage
